//--- src/subsys_pkg.sv
package subsys_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 64;

  // ------------------------------
  // Address map
  // ------------------------------
  typedef enum logic [1:0] {
    TGT_ROM   = 2'd0,
    TGT_CLINT = 2'd1,
    TGT_NONE  = 2'd2
  } target_e;

  // End address is exclusive
  typedef struct packed {
    target_e             idx;
    logic [ADDR_W-1:0]   start_addr;
    logic [ADDR_W-1:0]   end_addr;
  } addr_rule_t;

  localparam int unsigned NUM_RULES = 2;

  localparam addr_rule_t ADDR_MAP [NUM_RULES] = '{
    '{idx: TGT_ROM,   start_addr: 32'h0001_0000, end_addr: 32'h0002_0000},
    '{idx: TGT_CLINT, start_addr: 32'h0200_0000, end_addr: 32'h0200_C000}
  };

  // ------------------------------
  // Bus
  // ------------------------------
  typedef struct packed {
    logic                req;
    logic                we;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } bus_req_t;

  typedef struct packed {
    logic                valid;
    logic                err;
    logic [DATA_W-1:0]   rdata;
  } bus_rsp_t;

  // CLINT register offsets
  localparam logic [15:0] MSIP_OFS     = 16'h0000;
  localparam logic [15:0] MTIMECMP_OFS = 16'h4000;
  localparam logic [15:0] MTIME_OFS    = 16'hBFF8;

  // Boot image, two instructions per word
  localparam int unsigned ROM_WORDS = 16;

  localparam logic [DATA_W-1:0] BOOT_IMAGE [ROM_WORDS] = '{
    64'h0000_0297_f140_2573, 64'h0202_b283_0182_8293,
    64'h0102_8593_0002_8067, 64'h0000_0013_0000_0013,
    64'h3050_1073_0000_0517, 64'h0800_0593_0005_0513,
    64'h0005_8067_0000_0073, 64'h1050_0073_ffdf_f06f,
    64'h0200_0537_0045_0513, 64'h0005_2023_0000_0013,
    64'h8000_02b7_0002_8067, 64'h0000_0000_0000_0000,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210, 64'h5a5a_a5a5_3c3c_c3c3
  };

endpackage

//--- src/addr_decode.sv
module addr_decode import subsys_pkg::*; (
  input  bus_req_t bus_req_i,
  output target_e  tgt_o
);

  logic [NUM_RULES-1:0] hit;

  // ------------------------------
  // Rule match
  // ------------------------------
  always_comb begin
    hit   = '0;
    tgt_o = TGT_NONE;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (bus_req_i.req &&
          bus_req_i.addr >= ADDR_MAP[i].start_addr &&
          bus_req_i.addr <  ADDR_MAP[i].end_addr) begin
        hit[i] = 1'b1;
        tgt_o  = ADDR_MAP[i].idx;
      end
    end
  end

  // Overlapping rules would make the target depend on table order
  always_comb begin
    a_single_hit: assert final (!bus_req_i.req || $onehot0(hit))
      else $error("address %h hits more than one rule", bus_req_i.addr);
  end

endmodule

//--- src/boot_rom.sv
module boot_rom import subsys_pkg::*; (
  input  logic [ADDR_W-1:0] addr_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int unsigned IDX_W = $clog2(ROM_WORDS);

  logic [ADDR_W-1:0] offset;
  logic [ADDR_W-1:0] word_idx;

  // Byte offset from the ROM base, then 64-bit word index
  assign offset   = addr_i - ADDR_MAP[0].start_addr;
  assign word_idx = offset >> 3;

  always_comb begin
    if (word_idx < ROM_WORDS) begin
      rdata_o = BOOT_IMAGE[word_idx[IDX_W-1:0]];
    end else begin
      // Rest of the region reads as zero
      rdata_o = '0;
    end
  end

endmodule

//--- src/clint_timer.sv
module clint_timer import subsys_pkg::*; #(
  parameter int unsigned NUM_HARTS = 2
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 rtc_tick_i,
  input  bus_req_t             bus_req_i,
  input  target_e              tgt_i,
  output logic [DATA_W-1:0]    rdata_o,
  output logic [NUM_HARTS-1:0] timer_irq_o,
  output logic [NUM_HARTS-1:0] ipi_o
);

  logic [15:0]                          ofs;
  logic                                 wr_en;
  logic                                 rtc_phase_q;
  logic [DATA_W-1:0]                    mtime_q;
  logic [NUM_HARTS-1:0][DATA_W-1:0]     mtimecmp_q;
  logic [NUM_HARTS-1:0]                 msip_q;

  assign ofs   = 16'(bus_req_i.addr - ADDR_MAP[1].start_addr);
  assign wr_en = (tgt_i == TGT_CLINT) && bus_req_i.we;

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_phase_q <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= '0;
    end else begin
      // rtc divided by two
      if (rtc_tick_i) begin
        rtc_phase_q <= ~rtc_phase_q;
      end

      if (wr_en && ofs == MTIME_OFS) begin
        mtime_q <= bus_req_i.wdata;
      end else if (rtc_tick_i && rtc_phase_q) begin
        mtime_q <= mtime_q + 1'b1;
      end

      for (int h = 0; h < NUM_HARTS; h++) begin
        if (wr_en && ofs == MSIP_OFS + 16'(4 * h)) begin
          msip_q[h] <= bus_req_i.wdata[0];
        end
        if (wr_en && ofs == MTIMECMP_OFS + 16'(8 * h)) begin
          mtimecmp_q[h] <= bus_req_i.wdata;
        end
      end
    end
  end

  // ------------------------------
  // Read decode
  // ------------------------------
  always_comb begin
    rdata_o = '0;
    if (ofs == MTIME_OFS) begin
      rdata_o = mtime_q;
    end
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (ofs == MSIP_OFS + 16'(4 * h)) begin
        rdata_o = {{(DATA_W-1){1'b0}}, msip_q[h]};
      end
      if (ofs == MTIMECMP_OFS + 16'(8 * h)) begin
        rdata_o = mtimecmp_q[h];
      end
    end
  end

  // Interrupts
  always_comb begin
    for (int h = 0; h < NUM_HARTS; h++) begin
      timer_irq_o[h] = (mtime_q >= mtimecmp_q[h]);
    end
  end

  assign ipi_o = msip_q;

  // Software interrupts move only on a bus write
  a_ipi_from_write: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    $changed(ipi_o) |-> $past(wr_en)
  ) else $error("ipi changed without a CLINT write");

endmodule

//--- src/debug_req_gate.sv
module debug_req_gate import subsys_pkg::*; #(
  parameter int unsigned NUM_HARTS = 2,
  parameter int unsigned DMI_DELAY = 500
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic [NUM_HARTS-1:0] debug_req_i,
  output logic [NUM_HARTS-1:0] debug_req_o
);

  localparam int unsigned CNT_W = $clog2(DMI_DELAY + 1);

  logic [CNT_W-1:0] cnt_q;

  // Boot code runs before any debug request gets through
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CNT_W'(DMI_DELAY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : '0;

  a_gate_closed: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    (cnt_q != '0) |-> (debug_req_o == '0) ##1 (cnt_q == $past(cnt_q) - 1'b1)
  ) else $error("debug request passed while delay counter running");

endmodule

//--- src/bus_response.sv
module bus_response import subsys_pkg::*; (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  bus_req_t          bus_req_i,
  input  target_e           tgt_i,
  input  logic [DATA_W-1:0] rom_rdata_i,
  input  logic [DATA_W-1:0] clint_rdata_i,
  output bus_rsp_t          bus_rsp_o
);

  logic [DATA_W-1:0] rdata_d;
  logic              err_d;

  always_comb begin
    unique case (tgt_i)
      TGT_ROM:   rdata_d = rom_rdata_i;
      TGT_CLINT: rdata_d = clint_rdata_i;
      default:   rdata_d = '0;
    endcase
  end

  assign err_d = bus_req_i.req && (tgt_i == TGT_NONE);

  // ------------------------------
  // Response register
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      bus_rsp_o <= '0;
    end else begin
      bus_rsp_o.valid <= bus_req_i.req;
      bus_rsp_o.err   <= err_d;
      bus_rsp_o.rdata <= rdata_d;
    end
  end

  a_rsp_latency: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    bus_rsp_o.valid == $past(bus_req_i.req)
  ) else $error("response valid not one cycle after request");

endmodule

//--- src/soc_periph_subsys.sv
module soc_periph_subsys import subsys_pkg::*; #(
  parameter int unsigned NUM_HARTS = 2,
  parameter int unsigned DMI_DELAY = 500
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  bus_req_t             bus_req_i,
  output bus_rsp_t             bus_rsp_o,
  input  logic                 rtc_tick_i,
  output logic [NUM_HARTS-1:0] timer_irq_o,
  output logic [NUM_HARTS-1:0] ipi_o,
  input  logic [NUM_HARTS-1:0] debug_req_i,
  output logic [NUM_HARTS-1:0] debug_req_o
);

  target_e           tgt;
  logic [DATA_W-1:0] rom_rdata;
  logic [DATA_W-1:0] clint_rdata;

  addr_decode i_addr_decode (
    .bus_req_i ( bus_req_i ),
    .tgt_o     ( tgt       )
  );

  boot_rom i_boot_rom (
    .addr_i  ( bus_req_i.addr ),
    .rdata_o ( rom_rdata      )
  );

  clint_timer #(
    .NUM_HARTS ( NUM_HARTS )
  ) i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_tick_i  ( rtc_tick_i  ),
    .bus_req_i   ( bus_req_i   ),
    .tgt_i       ( tgt         ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_req_gate #(
    .NUM_HARTS ( NUM_HARTS ),
    .DMI_DELAY ( DMI_DELAY )
  ) i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  bus_response i_bus_response (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .bus_req_i     ( bus_req_i   ),
    .tgt_i         ( tgt         ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .bus_rsp_o     ( bus_rsp_o   )
  );

endmodule

//--- tb/tb_soc_periph_subsys.sv
module tb_soc_periph_subsys import subsys_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NUM_HARTS   = 2;
  localparam int unsigned DMI_DELAY   = 20;
  localparam int unsigned DBG_STEPS   = DMI_DELAY + 8;
  localparam int unsigned ROM_STEPS   = 64;
  localparam int unsigned UNM_STEPS   = 40;
  localparam int unsigned MSIP_STEPS  = 40;
  localparam int unsigned TIMER_STEPS = 160;
  localparam int unsigned TOTAL_STEPS = DBG_STEPS + ROM_STEPS + UNM_STEPS + MSIP_STEPS
                                        + TIMER_STEPS + 5 + 3;
  localparam int unsigned TIMEOUT     = 2 * TOTAL_STEPS + DMI_DELAY + 100;

  localparam logic [31:0] ROM_BASE    = 32'h0001_0000;
  localparam logic [31:0] ROM_END     = 32'h0002_0000;
  localparam logic [31:0] CLINT_BASE  = 32'h0200_0000;
  localparam logic [31:0] CLINT_END   = 32'h0200_C000;
  localparam logic [31:0] CMP_OFS     = 32'h0000_4000;
  localparam logic [31:0] MTIME_ADDR  = 32'h0200_BFF8;

  logic                 clk_i = 1'b0;
  logic                 ndmreset_n;
  bus_req_t             bus_req_i;
  bus_rsp_t             bus_rsp_o;
  logic                 rtc_tick_i;
  logic [NUM_HARTS-1:0] timer_irq_o;
  logic [NUM_HARTS-1:0] ipi_o;
  logic [NUM_HARTS-1:0] debug_req_i;
  logic [NUM_HARTS-1:0] debug_req_o;

  // Model state
  logic [63:0]          m_mtime;
  logic                 m_phase;
  logic [63:0]          m_cmp [NUM_HARTS];
  logic [NUM_HARTS-1:0] m_msip;
  logic                 exp_valid;
  logic                 exp_err;
  logic [63:0]          exp_rdata;

  logic [NUM_HARTS-1:0] dbg_in;
  logic [31:0] lfsr = 32'd77045;
  int unsigned cycles = 0;
  int unsigned rel_edges = 0;
  int unsigned n_checks = 0;
  int unsigned test_errs = 0;
  int unsigned n_tests = 0;
  int unsigned fail_tests = 0;
  string       cur_test;

  soc_periph_subsys #(
    .NUM_HARTS ( NUM_HARTS ),
    .DMI_DELAY ( DMI_DELAY )
  ) uut (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .bus_req_i   ( bus_req_i   ),
    .bus_rsp_o   ( bus_rsp_o   ),
    .rtc_tick_i  ( rtc_tick_i  ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  always #4 clk_i = ~clk_i;

  // Run limit and edges since reset release
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (ndmreset_n) begin
      rel_edges = rel_edges + 1;
    end
    if (cycles >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("tests failed");
      $finish;
    end
  end

  // ------------------------------
  // Random numbers and checks
  // ------------------------------
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  function automatic logic [NUM_HARTS-1:0] irq_model();
    logic [NUM_HARTS-1:0] v;
    for (int h = 0; h < NUM_HARTS; h++) begin
      v[h] = (m_mtime >= m_cmp[h]);
    end
    return v;
  endfunction

  // Expected response for a request and the model state after its edge
  task automatic predict(input logic do_req, input logic do_we, input logic [31:0] addr,
                         input logic [63:0] wdata, input logic tick);
    logic [31:0] ofs;
    logic [31:0] widx;
    logic        mtime_wr;
    ofs       = addr - CLINT_BASE;
    widx      = (addr - ROM_BASE) >> 3;
    mtime_wr  = 1'b0;
    exp_valid = do_req;
    exp_err   = 1'b0;
    exp_rdata = '0;
    if (do_req && addr >= ROM_BASE && addr < ROM_END) begin
      if (widx < ROM_WORDS) begin
        exp_rdata = BOOT_IMAGE[widx];
      end
    end else if (do_req && addr >= CLINT_BASE && addr < CLINT_END) begin
      if (addr == MTIME_ADDR) begin
        exp_rdata = m_mtime;
      end
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (ofs == 32'(4 * h)) exp_rdata = {63'b0, m_msip[h]};
        if (ofs == CMP_OFS + 32'(8 * h)) exp_rdata = m_cmp[h];
      end
      if (do_we) begin
        if (addr == MTIME_ADDR) begin
          m_mtime  = wdata;
          mtime_wr = 1'b1;
        end
        for (int h = 0; h < NUM_HARTS; h++) begin
          if (ofs == 32'(4 * h)) m_msip[h] = wdata[0];
          if (ofs == CMP_OFS + 32'(8 * h)) m_cmp[h] = wdata;
        end
      end
    end else if (do_req) begin
      exp_err = 1'b1;
    end
    if (tick && m_phase && !mtime_wr) begin
      m_mtime = m_mtime + 64'd1;
    end
    if (tick) begin
      m_phase = ~m_phase;
    end
  endtask

  // Drive at the rising edge and check at the falling edge
  task automatic step(input logic do_req, input logic do_we, input logic [31:0] addr,
                      input logic [63:0] wdata, input logic tick);
    logic [NUM_HARTS-1:0] dbg_exp;
    @(posedge clk_i);
    bus_req_i   <= '{req: do_req, we: do_we, addr: addr, wdata: wdata};
    rtc_tick_i  <= tick;
    debug_req_i <= dbg_in;
    @(negedge clk_i);
    dbg_exp = (rel_edges >= DMI_DELAY) ? debug_req_i : '0;
    check_val("valid", 64'(exp_valid), 64'(bus_rsp_o.valid));
    if (exp_valid) begin
      check_val("err", 64'(exp_err), 64'(bus_rsp_o.err));
      check_val("rdata", exp_rdata, bus_rsp_o.rdata);
    end
    check_val("timer_irq", 64'(irq_model()), 64'(timer_irq_o));
    check_val("ipi", 64'(m_msip), 64'(ipi_o));
    check_val("debug_req", 64'(dbg_exp), 64'(debug_req_o));
    predict(do_req, do_we, addr, wdata, tick);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    step(1'b0, 1'b0, '0, '0, 1'b0);
    n_tests++;
    if (test_errs == 0) begin
      $display("[PASS] %s", cur_test);
    end else begin
      $display("[FAIL] %s: %0d mismatches", cur_test, test_errs);
      fail_tests++;
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  initial begin
    logic [63:0] r;
    logic [31:0] addr;
    bus_req_i   = '0;
    rtc_tick_i  = 1'b0;
    debug_req_i = '1;
    dbg_in      = '1;
    ndmreset_n  = 1'b0;
    m_mtime     = '0;
    m_phase     = 1'b0;
    m_msip      = '0;
    exp_valid   = 1'b0;
    exp_err     = 1'b0;
    exp_rdata   = '0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      m_cmp[h] = '1;
    end
    repeat (3) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    start_test("debug_gate");
    for (int i = 0; i < DBG_STEPS; i++) begin
      // Requests vary once the gate is open
      if (i >= DMI_DELAY) begin
        dbg_in = NUM_HARTS'(rand_bits(NUM_HARTS));
      end
      step(1'b0, 1'b0, '0, '0, 1'b0);
    end
    end_test();

    start_test("rom_read");
    for (int i = 0; i < ROM_STEPS; i++) begin
      r    = rand_bits(3);
      addr = r[2] ? ROM_BASE + 32'(rand_bits(8)) : ROM_BASE + 32'(rand_bits(16));
      step(1'b1, r[1:0] == 2'b00, addr, rand_bits(64), 1'b0);
    end
    end_test();

    start_test("unmapped");
    for (int i = 0; i < UNM_STEPS; i++) begin
      r = rand_bits(3);
      case (r[1:0])
        2'd0:    addr = ROM_END + 32'(rand_bits(6));
        2'd1:    addr = CLINT_END + 32'(rand_bits(6));
        default: addr = 32'(rand_bits(32));
      endcase
      while ((addr >= ROM_BASE && addr < ROM_END) || (addr >= CLINT_BASE && addr < CLINT_END))
        addr = 32'(rand_bits(32));
      step(1'b1, r[2], addr, rand_bits(64), 1'b0);
    end
    end_test();

    start_test("msip");
    for (int i = 0; i < MSIP_STEPS; i++) begin
      r = rand_bits(2);
      step(1'b1, r[0], CLINT_BASE + 32'(4 * r[1]), rand_bits(64), 1'b0);
    end
    end_test();

    // Small values so mtime crosses the compare values often
    start_test("timer");
    for (int i = 0; i < TIMER_STEPS; i++) begin
      r = rand_bits(5);
      case (r[2:0])
        3'd0:      step(1'b1, 1'b1, MTIME_ADDR, rand_bits(6), r[4]);
        3'd1:      step(1'b1, 1'b1, CLINT_BASE + CMP_OFS + 32'(8 * r[3]), rand_bits(6), r[4]);
        3'd2, 3'd3: step(1'b1, 1'b0, MTIME_ADDR, rand_bits(64), r[4]);
        3'd4:      step(1'b1, 1'b0, CLINT_BASE + CMP_OFS + 32'(8 * r[3]), '0, r[4]);
        default:   step(1'b0, 1'b0, '0, '0, r[4]);
      endcase
    end
    end_test();

    $display("summary: %0d tests, %0d failing, %0d checks", n_tests, fail_tests, n_checks);
    if (fail_tests == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- src.f
src/subsys_pkg.sv
src/addr_decode.sv
src/boot_rom.sv
src/clint_timer.sv
src/debug_req_gate.sv
src/bus_response.sv
src/soc_periph_subsys.sv
tb/tb_soc_periph_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_periph_subsys
LOG       ?= sim.log
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP LOG FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "all tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
